// File: tb.f
+incdir+.
core_pkg.sv
if_stage.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
core.sv
core_sva.sv
tb_core.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f tb.f -o sim_core
./obj_dir/sim_core > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

// File: tb_core.sv
// Testbench for core with program load, retire table checks and a run limit.
module tb_core
    import core_pkg::*;
();
    localparam int RST_CYCLES = 16;
    localparam int PROG_LEN   = 16;
    localparam int EXP_LEN    = 10;
    localparam int MAX_CYCLES = RST_CYCLES + PROG_LEN + 20;

    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB.

    logic     clk = 1'b0;
    logic     arst_n;
    imem_wr_t imem_wr;
    retire_t  retire;

    word_t    prog [PROG_LEN];
    reg_idx_t exp_rd [EXP_LEN];
    word_t    exp_data [EXP_LEN];

    int cycles     = 0;
    int exp_idx    = 0;
    int value_errs = 0;
    int extra_errs = 0;

    core UUT (
        .clk     (clk    ),
        .arst_n  (arst_n ),
        .imem_wr (imem_wr),
        .retire  (retire )
    );

    bind core core_sva u_core_sva (
        .clk      (clk     ),
        .arst_n   (arst_n  ),
        .retire   (retire  ),
        .redirect (redirect),
        .ex_in    (ex_in   )
    );

    always #50 clk = ~clk;

    always @(posedge clk)
        cycles <= cycles + 1;

    function automatic word_t r_word(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_R};
    endfunction

    function automatic word_t i_word(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t s_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_word(int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic expect_retire(int idx, int rd, int data);
        exp_rd[idx]   = reg_idx_t'(rd);
        exp_data[idx] = word_t'(data);
    endtask

    task automatic fill_tables();
        prog[0]  = i_word(OPC_IMM, 3'b000, 1, 0, 5);  // addi x1, x0, 5
        prog[1]  = i_word(OPC_IMM, 3'b000, 2, 1, 7);  // addi x2, x1, 7
        prog[2]  = r_word(F7_BASE, 3'b000, 3, 1, 2);  // add x3, x1, x2
        prog[3]  = r_word(F7_ALT, 3'b000, 4, 3, 1);   // sub x4, x3, x1
        prog[4]  = r_word(F7_BASE, 3'b100, 5, 4, 3);  // xor x5, x4, x3
        prog[5]  = r_word(F7_BASE, 3'b111, 6, 5, 2);  // and x6, x5, x2
        prog[6]  = r_word(F7_BASE, 3'b110, 7, 6, 1);  // or x7, x6, x1
        prog[7]  = s_word(7, 0, 8);                   // sw x7, 8(x0)
        prog[8]  = i_word(OPC_LOAD, 3'b010, 8, 0, 8); // lw x8, 8(x0)
        prog[9]  = i_word(OPC_IMM, 3'b000, 0, 1, 1);  // addi x0, x1, 1
        prog[10] = r_word(F7_BASE, 3'b000, 9, 8, 0);  // add x9, x8, x0
        prog[11] = b_word(9, 1, 8);                   // beq x9, x1, +8 (not taken)
        prog[12] = b_word(9, 7, 12);                  // beq x9, x7, +12
        prog[13] = i_word(OPC_IMM, 3'b000, 11, 0, 99); // Flushed.
        prog[14] = i_word(OPC_IMM, 3'b000, 12, 0, 99); // Flushed.
        prog[15] = i_word(OPC_IMM, 3'b000, 10, 9, 1); // addi x10, x9, 1

        // Retire order, x0 writes and stores excluded.
        expect_retire(0, 1, 5);
        expect_retire(1, 2, 12);
        expect_retire(2, 3, 17);
        expect_retire(3, 4, 12);
        expect_retire(4, 5, 29); // 12 ^ 17.
        expect_retire(5, 6, 12); // 29 & 12.
        expect_retire(6, 7, 13);
        expect_retire(7, 8, 13); // Loaded back.
        expect_retire(8, 9, 13);
        expect_retire(9, 10, 14);
    endtask

    task automatic load_word(int idx);
        if (idx < PROG_LEN)
        begin
            imem_wr.en   = 1'b1;
            imem_wr.addr = imem_addr_t'(idx);
            imem_wr.data = prog[idx];
        end
        else
            imem_wr = '0;
    endtask

    task automatic check_retire();
        assert (exp_idx < EXP_LEN)
        else
        begin
            extra_errs++;
            $display("Retire of x%0d at time %0t with no expected entry left", retire.rd, $time);
        end
        if (exp_idx < EXP_LEN)
        begin
            assert (retire.rd == exp_rd[exp_idx])
            else
            begin
                value_errs++;
                $display("CHECK FAILED time %0t retire.rd expected %0d actual %0d",
                         $time, exp_rd[exp_idx], retire.rd);
            end
            assert (retire.data == exp_data[exp_idx])
            else
            begin
                value_errs++;
                $display("CHECK FAILED time %0t retire.data expected 0x%08h actual 0x%08h",
                         $time, exp_data[exp_idx], retire.data);
            end
            exp_idx++;
        end
    endtask

    // Retire is registered, so sample mid-cycle.
    always @(negedge clk)
    begin
        if (retire.valid)
            check_retire();
    end

    initial
    begin
        int missing_errs;
        missing_errs = 0;
        arst_n       = 1'b0;
        imem_wr      = '0;
        fill_tables();
        for (int i = 0; i < RST_CYCLES; i++)
        begin
            @(posedge clk);
            #5;
            load_word(i);
        end
        @(posedge clk);
        #5;
        imem_wr = '0;
        arst_n  = 1'b1;

        while (cycles < MAX_CYCLES)
            @(posedge clk);
        #60; // Past the last sample point.

        assert (exp_idx == EXP_LEN)
        else
        begin
            missing_errs = 1;
            $display("Run ended with %0d of %0d expected retires missing",
                     EXP_LEN - exp_idx, EXP_LEN);
        end
        $display("Error counts: %0d value, %0d extra retire, %0d missing retire",
                 value_errs, extra_errs, missing_errs);
        if (value_errs + extra_errs + missing_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule : tb_core

// File: core_sva.sv
// Concurrent assertions on the core retire port and branch redirect.
module core_sva
    import core_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input retire_t   retire,
    input redirect_t redirect,
    input id_out_t   ex_in
);

    // Pipeline registers are cleared in reset.
    no_retire_in_reset: assert property (@(posedge clk) !arst_n |-> !retire.valid)
        else $error("retire valid while reset is asserted");

    retire_rd_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n) retire.valid |-> retire.rd != '0)
        else $error("retire reported a write to register zero");

    // Only a live BEQ may redirect, and it leaves a bubble in execute.
    redirect_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect.taken |=> $past(ex_in.valid) && !ex_in.valid)
        else $error("redirect taken with no valid instruction or no bubble after it");

endmodule : core_sva

// File: core.sv
// Pipeline top with stage instances, stage registers, flush and retire port.
module core
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  imem_wr_t imem_wr,
    output retire_t  retire
);
    if_out_t   if_out;
    if_out_t   id_in;
    id_out_t   id_out;
    id_out_t   ex_in;
    ex_out_t   ex_out;
    ex_out_t   mem_in;
    mem_out_t  mem_out;
    mem_out_t  wb_in;
    redirect_t redirect;
    fwd_t      fwd_mem;
    fwd_t      fwd_wb;

    if_stage u_if_stage (
        .clk      (clk     ),
        .arst_n   (arst_n  ),
        .redirect (redirect),
        .imem_wr  (imem_wr ),
        .if_out   (if_out  )
    );

    id_stage u_id_stage (
        .clk    (clk   ),
        .arst_n (arst_n),
        .id_in  (id_in ),
        .wb_in  (fwd_wb), // Register file write.
        .id_out (id_out)
    );

    ex_stage u_ex_stage (
        .ex_in    (ex_in   ),
        .fwd_mem  (fwd_mem ),
        .fwd_wb   (fwd_wb  ),
        .ex_out   (ex_out  ),
        .redirect (redirect)
    );

    mem_stage u_mem_stage (
        .clk     (clk    ),
        .mem_in  (mem_in ),
        .mem_out (mem_out)
    );

    always_comb
    begin
        fwd_mem.rf_en = mem_in.rf_en && !mem_in.mem_rd; // Load data not ready yet.
        fwd_mem.rd    = mem_in.rd;
        fwd_mem.value = mem_in.opr_res;
        fwd_wb.rf_en  = wb_in.rf_en;
        fwd_wb.rd     = wb_in.rd;
        fwd_wb.value  = wb_in.result;
        retire.valid  = wb_in.valid && wb_in.rf_en;
        retire.rd     = wb_in.rd;
        retire.data   = wb_in.result;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            id_in  <= '0;
            ex_in  <= '0;
            mem_in <= '0;
            wb_in  <= '0;
        end
        else
        begin
            // Taken branch kills the two younger instructions.
            id_in  <= redirect.taken ? '0 : if_out;
            ex_in  <= redirect.taken ? '0 : id_out;
            mem_in <= ex_out;
            wb_in  <= mem_out;
        end
    end

endmodule : core

// File: mem_stage.sv
// Memory stage with data memory and result select.
`include "core_params.svh"

module mem_stage
    import core_pkg::*;
(
    input  logic     clk,
    input  ex_out_t  mem_in,
    output mem_out_t mem_out
);
    localparam int DMEM_AW = $clog2(`CORE_DMEM_WORDS);

    word_t              dmem [`CORE_DMEM_WORDS];
    logic [DMEM_AW-1:0] addr;

    assign addr = mem_in.opr_res[DMEM_AW+1:2]; // Word address.

    always_ff @(posedge clk)
    begin
        if (mem_in.valid && mem_in.mem_wr)
            dmem[addr] <= mem_in.store_data;
    end

    always_comb
    begin
        mem_out.valid  = mem_in.valid;
        mem_out.rd     = mem_in.rd;
        mem_out.rf_en  = mem_in.rf_en;
        mem_out.result = mem_in.mem_rd ? dmem[addr] : mem_in.opr_res; // Async read.
    end

endmodule : mem_stage

// File: ex_stage.sv
// Execute stage with operand forwarding, ALU and BEQ resolution.
module ex_stage
    import core_pkg::*;
(
    input  id_out_t   ex_in,
    input  fwd_t      fwd_mem,
    input  fwd_t      fwd_wb,
    output ex_out_t   ex_out,
    output redirect_t redirect
);
    word_t opa;
    word_t opb_reg;
    word_t opb;
    word_t alu_res;

    // Youngest producer first.
    function automatic word_t fwd_sel(reg_idx_t idx, word_t dec_val);
        word_t val;
        if (fwd_mem.rf_en && fwd_mem.rd != '0 && fwd_mem.rd == idx)
            val = fwd_mem.value;
        else if (fwd_wb.rf_en && fwd_wb.rd != '0 && fwd_wb.rd == idx)
            val = fwd_wb.value;
        else
            val = dec_val;
        return val;
    endfunction

    always_comb
    begin
        opa     = fwd_sel(ex_in.rs1, ex_in.rs1_val);
        opb_reg = fwd_sel(ex_in.rs2, ex_in.rs2_val);
        opb     = ex_in.use_imm ? ex_in.imm : opb_reg;
    end

    always_comb
    begin
        case (ex_in.alu_op)
            ALU_SUB: alu_res = opa - opb;
            ALU_AND: alu_res = opa & opb;
            ALU_OR:  alu_res = opa | opb;
            ALU_XOR: alu_res = opa ^ opb;
            default: alu_res = opa + opb; // Also load and store address.
        endcase
    end

    always_comb
    begin
        ex_out.valid      = ex_in.valid;
        ex_out.rd         = ex_in.rd;
        ex_out.rf_en      = ex_in.rf_en;
        ex_out.mem_rd     = ex_in.mem_rd;
        ex_out.mem_wr     = ex_in.mem_wr;
        ex_out.opr_res    = alu_res;
        ex_out.store_data = opb_reg;
    end

    // BEQ compares the forwarded register values.
    always_comb
    begin
        redirect.taken  = ex_in.valid && ex_in.branch && (opa == opb_reg);
        redirect.target = ex_in.pc + ex_in.imm;
    end

endmodule : ex_stage

// File: id_stage.sv
// Decode stage with register file, write-first bypass and bubble insertion.
`include "core_params.svh"

module id_stage
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  if_out_t id_in,
    input  fwd_t    wb_in,
    output id_out_t id_out
);
    word_t  rf [`CORE_NREGS];
    instr_u ins;
    logic   known;

    assign ins = id_in.instr;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            rf <= '{default: '0};
        else if (wb_in.rf_en && wb_in.rd != '0)
            rf[wb_in.rd] <= wb_in.value;
    end

    // Same-cycle writeback wins over the stored value.
    function automatic word_t rf_read(reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (wb_in.rf_en && wb_in.rd == idx)
            val = wb_in.value;
        else
            val = rf[idx];
        return val;
    endfunction

    always_comb
    begin
        id_out    = '0;
        id_out.pc = id_in.pc;
        known     = 1'b0;
        case (ins.r.opcode)
            OP_R:
            begin
                id_out.rs1   = ins.r.rs1;
                id_out.rs2   = ins.r.rs2;
                id_out.rd    = ins.r.rd;
                id_out.rf_en = 1'b1;
                known        = 1'b1;
                case (ins.r.funct3)
                    3'b000:  id_out.alu_op = ins.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b100:  id_out.alu_op = ALU_XOR;
                    3'b110:  id_out.alu_op = ALU_OR;
                    3'b111:  id_out.alu_op = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OP_IMM, OP_LOAD:
            begin
                id_out.rs1     = ins.i.rs1;
                id_out.rd      = ins.i.rd;
                id_out.imm     = {{(`CORE_XLEN-12){ins.i.imm[11]}}, ins.i.imm};
                id_out.use_imm = 1'b1;
                id_out.rf_en   = 1'b1;
                id_out.mem_rd  = (ins.i.opcode == OP_LOAD);
                // ADDI or LW only.
                known = (ins.i.funct3 == (id_out.mem_rd ? 3'b010 : 3'b000));
            end
            OP_STORE:
            begin
                id_out.rs1     = ins.s.rs1;
                id_out.rs2     = ins.s.rs2;
                id_out.imm     = {{(`CORE_XLEN-12){ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
                id_out.use_imm = 1'b1;
                id_out.mem_wr  = 1'b1;
                known          = (ins.s.funct3 == 3'b010); // SW.
            end
            OP_BRANCH:
            begin
                id_out.rs1    = ins.b.rs1;
                id_out.rs2    = ins.b.rs2;
                id_out.imm    = {{(`CORE_XLEN-13){ins.b.imm12}}, ins.b.imm12, ins.b.imm11,
                                 ins.b.imm10_5, ins.b.imm4_1, 1'b0};
                id_out.branch = 1'b1;
                known         = (ins.b.funct3 == 3'b000); // BEQ.
            end
            default: known = 1'b0;
        endcase
        id_out.rf_en   = id_out.rf_en && (id_out.rd != '0); // x0 writes dropped.
        id_out.rs1_val = rf_read(id_out.rs1);
        id_out.rs2_val = rf_read(id_out.rs2);
        id_out.valid   = id_in.valid && known;
        if (!id_out.valid)
            id_out = '0; // Unsupported word becomes a bubble.
    end

endmodule : id_stage

// File: if_stage.sv
// Fetch stage with program counter, instruction memory and branch redirect.
`include "core_params.svh"

module if_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  redirect_t redirect,
    input  imem_wr_t  imem_wr,
    output if_out_t   if_out
);
    localparam int IMEM_AW = $clog2(`CORE_IMEM_WORDS);

    word_t imem [`CORE_IMEM_WORDS];
    word_t pc;

    // Program load port.
    always_ff @(posedge clk)
    begin
        if (imem_wr.en)
            imem[imem_wr.addr] <= imem_wr.data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pc <= '0;
        else if (redirect.taken)
            pc <= redirect.target; // Taken BEQ from execute.
        else
            pc <= pc + word_t'(4);
    end

    always_comb
    begin
        if_out.valid = 1'b1;
        if_out.pc    = pc;
        if_out.instr = imem[pc[IMEM_AW+1:2]]; // Word addressed.
    end

endmodule : if_stage

// File: core_pkg.sv
// Instruction union, opcode and ALU enums, stage and port structs.
`include "core_params.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]                word_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0]      reg_idx_t;
    typedef logic [$clog2(`CORE_IMEM_WORDS)-1:0] imem_addr_t;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
    } instr_u;

    typedef struct packed {logic valid; word_t pc; instr_u instr;} if_out_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        logic     use_imm;
        reg_idx_t rd;
        logic     rf_en;
        logic     mem_rd;
        logic     mem_wr;
        logic     branch;
    } id_out_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rf_en;
        logic     mem_rd;
        logic     mem_wr;
        word_t    opr_res;
        word_t    store_data;
    } ex_out_t;

    typedef struct packed {logic valid; reg_idx_t rd; logic rf_en; word_t result;} mem_out_t;
    typedef struct packed {logic rf_en; reg_idx_t rd; word_t value;} fwd_t;
    typedef struct packed {logic taken; word_t target;} redirect_t;
    typedef struct packed {logic en; imem_addr_t addr; word_t data;} imem_wr_t;
    typedef struct packed {logic valid; reg_idx_t rd; word_t data;} retire_t;

endpackage

// File: core_params.svh
// Width, register count and memory depth macros.
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width.
`define CORE_XLEN 32

`define CORE_NREGS 32

// Memory depths in words.
`define CORE_IMEM_WORDS 256
`define CORE_DMEM_WORDS 256

`endif
